/* controlPkg.sv */
package controlPkg;

    // instruction field widths
    localparam int opcodeWidth = 6;
    localparam int functWidth  = 6;

    // step counter, wide enough for the longest fetch phase plus dispatch
    localparam int stepWidth = 3;

    typedef enum logic [opcodeWidth-1:0] {
        opR    = 6'b000000,
        opJ    = 6'b000010,
        opJal  = 6'b000011,
        opAddi = 6'b001000,
        opHalt = 6'b111111
    } opcodeT;

    typedef enum logic [functWidth-1:0] {
        fnSll   = 6'b000000,
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100,
        fnSlt   = 6'b101010,
        fnBreak = 6'b111111
    } functT;

    // stFetch covers fetch, decode and dispatch
    typedef enum logic [3:0] {
        stFetch = 4'd0,
        stAdd   = 4'd1,
        stSub   = 4'd2,
        stAnd   = 4'd3,
        stAddi  = 4'd4,
        stSll   = 4'd5,
        stSlt   = 4'd6,
        stJ     = 4'd7,
        stJal   = 4'd8,
        stBreak = 4'd9,
        stHalt  = 4'd10
    } stateT;

    typedef enum logic [2:0] {
        aluPassA   = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        srcBRegB      = 2'b00,
        srcBFour      = 2'b01,
        srcBImmediate = 2'b10
    } srcBSelT;

    typedef enum logic [1:0] {
        destRt     = 2'b00,
        destRd     = 2'b01,
        destReturn = 2'b10 // register 31
    } regDestSelT;

    typedef enum logic [3:0] {
        wbAluOut  = 4'b0000,
        wbCompare = 4'b0100,
        wbShifter = 4'b1000
    } memToRegSelT;

    typedef enum logic [2:0] {
        shNone = 3'b000,
        shLoad = 3'b001,
        shLeft = 3'b010
    } shiftOpT;

endpackage

/* instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input  controlPkg::opcodeT opcode,
    input  controlPkg::functT  funct,
    output controlPkg::stateT  dispatchState
);
    import controlPkg::*;

    stateT rTypeState;

    // R-type instructions pick their sequence from the function field
    always_comb begin
        case (funct)
            fnAdd:   rTypeState = stAdd;
            fnSub:   rTypeState = stSub;
            fnAnd:   rTypeState = stAnd;
            fnSll:   rTypeState = stSll;
            fnSlt:   rTypeState = stSlt;
            fnBreak: rTypeState = stBreak;
            default: rTypeState = stFetch; // unknown funct is a no-op
        endcase
    end

    always_comb begin
        case (opcode)
            opR: begin
                dispatchState = rTypeState;
            end
            opAddi: begin
                dispatchState = stAddi;
            end
            opJ: begin
                dispatchState = stJ;
            end
            opJal: begin
                dispatchState = stJal;
            end
            opHalt: begin
                dispatchState = stHalt;
            end
            default: begin
                dispatchState = stFetch; // back to fetch
            end
        endcase
    end

endmodule

/* stepSequencer.sv */
`timescale 1ns/10ps

module stepSequencer #(
    parameter int fetchSteps = 4
) (
    input  logic                             clock,
    input  logic                             reset,
    input  controlPkg::stateT                dispatchState,
    output controlPkg::stateT                state,
    output logic [controlPkg::stepWidth-1:0] step
);
    import controlPkg::*;

    // fetch runs steps 0..F-1, decode at F, dispatch at F+1
    localparam logic [stepWidth-1:0] dispatchStep = stepWidth'(fetchSteps + 1);

    logic [stepWidth-1:0] lastStep;
    stateT                nextState;
    logic [stepWidth-1:0] nextStep;

    // final step of each sequence
    always_comb begin
        case (state)
            stFetch: begin
                lastStep = dispatchStep;
            end
            stAdd, stSub, stAnd, stAddi, stJal, stBreak: begin
                lastStep = stepWidth'(1); // two cycles
            end
            stSll: begin
                lastStep = stepWidth'(2); // load, shift, write back
            end
            default: begin
                lastStep = '0; // slt, j and halt
            end
        endcase
    end

    always_comb begin
        nextState = state;
        nextStep  = step + 1'b1;
        if (state == stHalt) begin
            nextState = stHalt; // held until reset
            nextStep  = '0;
        end else if (step == lastStep) begin
            nextStep = '0;
            if (state == stFetch) begin
                nextState = dispatchState;
            end else begin
                nextState = stFetch;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stFetch;
            step  <= '0;
        end else begin
            state <= nextState;
            step  <= nextStep;
        end
    end

endmodule

/* controlWordGen.sv */
`timescale 1ns/10ps

module controlWordGen #(
    parameter int fetchSteps = 4
) (
    input  controlPkg::stateT                state,
    input  logic [controlPkg::stepWidth-1:0] step,
    output logic                             pcWrite,
    output logic                             irWrite,
    output logic                             regWrite,
    output logic                             aWrite,
    output logic                             bWrite,
    output logic                             aluOutWrite,
    output controlPkg::aluOpT                aluOp,
    output logic                             srcASel,
    output controlPkg::srcBSelT              srcBSel,
    output controlPkg::regDestSelT           regDestSel,
    output controlPkg::memToRegSelT          memToRegSel,
    output logic                             pcSrcSel,
    output logic                             shiftAmtSel,
    output logic                             shiftSrcSel,
    output controlPkg::shiftOpT              shiftOp,
    output logic                             resetOut
);
    import controlPkg::*;

    localparam logic [stepWidth-1:0] lastFetchStep = stepWidth'(fetchSteps - 1);
    localparam logic [stepWidth-1:0] decodeStep    = stepWidth'(fetchSteps);

    always_comb begin
        // everything inactive unless a state says otherwise
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aWrite      = 1'b0;
        bWrite      = 1'b0;
        aluOutWrite = 1'b0;
        aluOp       = aluPassA;
        srcASel     = 1'b0;
        srcBSel     = srcBRegB;
        regDestSel  = destRt;
        memToRegSel = wbAluOut;
        pcSrcSel    = 1'b0;
        shiftAmtSel = 1'b0;
        shiftSrcSel = 1'b0;
        shiftOp     = shNone;
        resetOut    = 1'b0;

        case (state)
            stFetch: begin
                if (step < decodeStep) begin
                    aluOp   = aluAdd; // pc + 4
                    srcBSel = srcBFour;
                    if (step == lastFetchStep) begin
                        pcWrite = 1'b1;
                        irWrite = 1'b1;
                    end
                end else if (step == decodeStep) begin
                    aWrite = 1'b1; // operand registers
                    bWrite = 1'b1;
                end
            end

            stAdd, stSub, stAnd: begin
                srcASel = 1'b1;
                case (state)
                    stSub:   aluOp = aluSub;
                    stAnd:   aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
                if (step == '0) begin
                    aluOutWrite = 1'b1;
                end else begin
                    regWrite   = 1'b1;
                    regDestSel = destRd;
                end
            end

            stAddi: begin
                srcASel = 1'b1;
                aluOp   = aluAdd;
                srcBSel = srcBImmediate;
                if (step == '0) begin
                    aluOutWrite = 1'b1;
                end else begin
                    regWrite   = 1'b1;
                    regDestSel = destRt;
                end
            end

            stSll: begin
                regDestSel  = destRd;
                memToRegSel = wbShifter;
                if (step == '0) begin
                    shiftAmtSel = 1'b1; // shamt field
                    shiftSrcSel = 1'b1; // from register B
                    shiftOp     = shLoad;
                end else if (step == stepWidth'(1)) begin
                    shiftOp = shLeft;
                end else begin
                    regWrite = 1'b1;
                end
            end

            stSlt: begin
                regWrite    = 1'b1;
                srcASel     = 1'b1;
                aluOp       = aluCompare;
                regDestSel  = destRd;
                memToRegSel = wbCompare;
            end

            stJ: begin
                pcWrite  = 1'b1;
                pcSrcSel = 1'b1; // jump target
            end

            stJal: begin
                if (step == '0) begin
                    aluOutWrite = 1'b1; // save return address
                end else begin
                    pcWrite    = 1'b1;
                    pcSrcSel   = 1'b1;
                    regWrite   = 1'b1;
                    regDestSel = destReturn;
                end
            end

            stBreak: begin
                aluOp   = aluSub; // pc - 4
                srcBSel = srcBFour;
                if (step != '0) begin
                    pcWrite = 1'b1;
                end
            end

            stHalt: begin
                resetOut = 1'b1;
            end

            default: begin
            end
        endcase
    end

endmodule

/* controlUnit.sv */
`timescale 1ns/10ps

module controlUnit #(
    parameter int fetchSteps = 4 // 2 to 5
) (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::opcodeT      opcode,
    input  controlPkg::functT       funct,
    output logic                    pcWrite,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    aWrite,
    output logic                    bWrite,
    output logic                    aluOutWrite,
    output controlPkg::aluOpT       aluOp,
    output logic                    srcASel,
    output controlPkg::srcBSelT     srcBSel,
    output controlPkg::regDestSelT  regDestSel,
    output controlPkg::memToRegSelT memToRegSel,
    output logic                    pcSrcSel,
    output logic                    shiftAmtSel,
    output logic                    shiftSrcSel,
    output controlPkg::shiftOpT     shiftOp,
    output logic                    resetOut
);
    import controlPkg::*;

    stateT                dispatchState;
    stateT                state;
    logic [stepWidth-1:0] step;

    instrDecoder decoder_i (
        .opcode        (opcode),
        .funct         (funct),
        .dispatchState (dispatchState)
    );

    stepSequencer #(
        .fetchSteps (fetchSteps)
    ) sequencer_i (
        .clock         (clock),
        .reset         (reset),
        .dispatchState (dispatchState),
        .state         (state),
        .step          (step)
    );

    controlWordGen #(
        .fetchSteps (fetchSteps)
    ) wordGen_i (
        .state       (state),
        .step        (step),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .aluOp       (aluOp),
        .srcASel     (srcASel),
        .srcBSel     (srcBSel),
        .regDestSel  (regDestSel),
        .memToRegSel (memToRegSel),
        .pcSrcSel    (pcSrcSel),
        .shiftAmtSel (shiftAmtSel),
        .shiftSrcSel (shiftSrcSel),
        .shiftOp     (shiftOp),
        .resetOut    (resetOut)
    );

endmodule

/* controlUnitTb.sv */
`timescale 1ns/10ps

module controlUnitTb;
    import controlPkg::*;

    localparam int fetchSteps = 4;
    localparam int numInstr   = 60;
    // longest instruction is fetchSteps + 5 cycles
    localparam int cycleLimit = numInstr * (fetchSteps + 5) + 50;

    typedef enum int {
        insAdd, insSub, insAnd, insSll, insSlt, insBreak,
        insAddi, insJ, insJal, insUnknown, insHalt
    } instrT;

    logic        clock;
    logic        reset;
    opcodeT      opcode;
    functT       funct;
    logic        pcWrite;
    logic        irWrite;
    logic        regWrite;
    logic        aWrite;
    logic        bWrite;
    logic        aluOutWrite;
    aluOpT       aluOp;
    logic        srcASel;
    srcBSelT     srcBSel;
    regDestSelT  regDestSel;
    memToRegSelT memToRegSel;
    logic        pcSrcSel;
    logic        shiftAmtSel;
    logic        shiftSrcSel;
    shiftOpT     shiftOp;
    logic        resetOut;

    logic [31:0] lfsr = 32'hda16;
    instrT       curCode = insUnknown; // instruction held in the IR
    logic        firstFetch = 1'b1;    // no irWrite yet since reset
    logic        irSeen = 1'b0;
    logic        resetSampled;
    int          idx = 0;              // cycles since last irWrite
    int          errors = 0;
    int          checks = 0;
    int          haltCycles = 0;
    int          decodes = 0;
    int          instrCount = 0;
    int          cycles = 0;

    controlUnit #(
        .fetchSteps (fetchSteps)
    ) dut_i (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] lfsrStep(input logic [31:0] value);
        logic feedback;
        feedback = value[31] ^ value[21] ^ value[1] ^ value[0];
        return {value[30:0], feedback};
    endfunction

    function automatic int execLength(input instrT code);
        case (code)
            insSll:              return 3;
            insSlt, insJ:        return 1;
            insUnknown, insHalt: return 0;
            default:             return 2;
        endcase
    endfunction

    // uniform over the ten codes other than halt
    task automatic pickCode(output instrT code);
        logic [3:0] bits;
        bits = 4'hf;
        while (bits > 4'd9) begin
            bits = '0;
            for (int i = 0; i < 4; i++) begin
                lfsr = lfsrStep(lfsr);
                bits = {bits[2:0], lfsr[0]};
            end
        end
        code = instrT'(int'(bits));
    endtask

    task automatic driveCode(input instrT code);
        opcode <= opR;
        funct  <= fnAdd;
        case (code)
            insSub:     funct <= fnSub;
            insAnd:     funct <= fnAnd;
            insSll:     funct <= fnSll;
            insSlt:     funct <= fnSlt;
            insBreak:   funct <= fnBreak;
            insAddi:    opcode <= opAddi;
            insJ:       opcode <= opJ;
            insJal:     opcode <= opJal;
            insUnknown: opcode <= opcodeT'(6'b000100); // beq, not decoded
            insHalt:    opcode <= opHalt;
            default:    opcode <= opR;
        endcase
    endtask

    task automatic compareField(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        checks++;
        assert (got === expected)
        else begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic expectQuiet();
        compareField("pcWrite", 8'(pcWrite), 8'h0);
        compareField("irWrite", 8'(irWrite), 8'h0);
        compareField("regWrite", 8'(regWrite), 8'h0);
        compareField("aWrite", 8'(aWrite), 8'h0);
        compareField("bWrite", 8'(bWrite), 8'h0);
        compareField("aluOutWrite", 8'(aluOutWrite), 8'h0);
        compareField("resetOut", 8'(resetOut), 8'h0);
    endtask

    // selectors in the final execute step
    task automatic checkSelectors();
        case (curCode)
            insAdd: compareField("aluOp", 8'(aluOp), 8'(aluAdd));
            insSub: compareField("aluOp", 8'(aluOp), 8'(aluSub));
            insAnd: compareField("aluOp", 8'(aluOp), 8'(aluAnd));
            insAddi: begin
                compareField("regDestSel", 8'(regDestSel), 8'(destRt));
                compareField("srcBSel", 8'(srcBSel), 8'(srcBImmediate));
            end
            insSlt: begin
                compareField("memToRegSel", 8'(memToRegSel), 8'(wbCompare));
                compareField("aluOp", 8'(aluOp), 8'(aluCompare));
            end
            insSll: compareField("memToRegSel", 8'(memToRegSel), 8'(wbShifter));
            insJ: compareField("pcSrcSel", 8'(pcSrcSel), 8'h1);
            insJal: begin
                compareField("pcSrcSel", 8'(pcSrcSel), 8'h1);
                compareField("regDestSel", 8'(regDestSel), 8'(destReturn));
            end
            insBreak: begin
                compareField("aluOp", 8'(aluOp), 8'(aluSub));
                compareField("srcBSel", 8'(srcBSel), 8'(srcBFour));
                compareField("pcSrcSel", 8'(pcSrcSel), 8'h0);
                compareField("srcASel", 8'(srcASel), 8'h0); // pc as operand
            end
            default: begin
            end
        endcase
        if (curCode inside {insAdd, insSub, insAnd, insAddi, insSlt}) begin
            compareField("srcASel", 8'(srcASel), 8'h1); // register A
        end
        if (curCode inside {insAdd, insSub, insAnd, insSll, insSlt}) begin
            compareField("regDestSel", 8'(regDestSel), 8'(destRd));
        end
        if (curCode inside {insAdd, insSub, insAnd}) begin
            compareField("memToRegSel", 8'(memToRegSel), 8'(wbAluOut));
        end
    endtask

    // load, shift left, then write back
    task automatic shifterCheck(input int position);
        shiftOpT expOp;
        logic    expLoad;
        expLoad = (position == 0);
        case (position)
            0:       expOp = shLoad;
            1:       expOp = shLeft;
            default: expOp = shNone;
        endcase
        compareField("shiftOp", 8'(shiftOp), 8'(expOp));
        compareField("shiftAmtSel", 8'(shiftAmtSel), 8'(expLoad));
        compareField("shiftSrcSel", 8'(shiftSrcSel), 8'(expLoad));
    endtask

    // expected enables from the instruction in flight and idx
    task automatic followModel();
        int   len;
        logic expPc;
        logic expIr;
        logic expReg;
        logic expAb;
        logic expAluOut;
        logic expRst;
        logic lastStep;
        len       = execLength(curCode);
        expPc     = 1'b0;
        expIr     = 1'b0;
        expReg    = 1'b0;
        expAb     = 1'b0;
        expAluOut = 1'b0;
        expRst    = 1'b0;
        if (firstFetch) begin
            expIr = (idx == fetchSteps - 1);
            expPc = expIr;
        end else if (idx == 1) begin
            expAb = 1'b1; // decode
            decodes++;
        end else if (curCode == insHalt) begin
            expRst = (idx >= 3);
            if (expRst) begin
                haltCycles++;
            end
        end else if (idx >= 3 && idx < 3 + len) begin
            lastStep = (idx == 2 + len);
            case (curCode)
                insJ:           expPc = 1'b1;
                insBreak:       expPc = lastStep;
                insSll, insSlt: expReg = lastStep;
                insJal: begin
                    expAluOut = !lastStep;
                    expPc     = lastStep;
                    expReg    = lastStep;
                end
                default: begin
                    expAluOut = !lastStep;
                    expReg    = lastStep;
                end
            endcase
            if (curCode == insSll) begin
                shifterCheck(idx - 3);
            end
            if (lastStep) begin
                checkSelectors();
            end
        end else if (idx == fetchSteps + 2 + len) begin
            expIr = 1'b1;
            expPc = 1'b1;
        end
        compareField("pcWrite", 8'(pcWrite), 8'(expPc));
        compareField("irWrite", 8'(irWrite), 8'(expIr));
        compareField("regWrite", 8'(regWrite), 8'(expReg));
        compareField("aWrite", 8'(aWrite), 8'(expAb));
        compareField("bWrite", 8'(bWrite), 8'(expAb));
        compareField("aluOutWrite", 8'(aluOutWrite), 8'(expAluOut));
        compareField("resetOut", 8'(resetOut), 8'(expRst));
        if (irWrite) begin
            if (!firstFetch) begin
                compareField("irWrite interval", 8'(idx), 8'(fetchSteps + 2 + len));
            end
            firstFetch = 1'b0;
            idx        = 0;
        end
    endtask

    assert property (@(negedge clock) disable iff (reset) irWrite |-> pcWrite)
    else begin
        errors++;
        $display("FAIL irWrite came without pcWrite at %0t", $time);
    end

    assert property (@(negedge clock) disable iff (reset)
        resetOut |-> !(pcWrite || irWrite || regWrite || aWrite || bWrite || aluOutWrite))
    else begin
        errors++;
        $display("FAIL a write enable was high during halt at %0t", $time);
    end

    always @(posedge clock) resetSampled <= reset;

    // outputs are checked mid-cycle
    always @(negedge clock) begin
        if (resetSampled) begin
            expectQuiet();
        end
        if (reset) begin
            firstFetch = 1'b1;
            idx        = 0;
            irSeen     = 1'b0;
        end else begin
            followModel();
            irSeen = irWrite;
            idx++;
        end
    end

    always @(posedge clock) begin
        if (irSeen) begin
            if (instrCount == numInstr) begin
                curCode = insHalt;
            end else begin
                pickCode(curCode);
            end
            instrCount++;
            driveCode(curCode);
        end
    end

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", cycleLimit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int mark;
        clock  = 1'b0;
        reset  = 1'b1;
        opcode = opR;
        funct  = fnAdd;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        wait (haltCycles >= 8); // halt held for a while
        @(posedge clock);
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        mark = decodes;
        wait (decodes > mark); // fetch and decode again after reset
        @(posedge clock);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* controlUnit.f */
controlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
controlUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and simulate the control unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module controlUnitTb -f controlUnit.f -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

./obj_dir/controlUnitSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
exit 0
